// File: stream_mux_cfg.svh
// ********************
// Stream selector configuration
// Widths, channel count, buffer depth and credit counts
// ********************

`ifndef STREAM_MUX_CFG_SVH
`define STREAM_MUX_CFG_SVH

// Word fields carried by every channel
`define DATA_WIDTH 16
`define DEST_WIDTH 8
`define USER_WIDTH 8

// Channel count and the address that picks one of them
`define CHANNEL_COUNT 5
`define CHANNEL_INDEX_WIDTH 3

// Each source starts with one credit per buffer slot
`define BUFFER_DEPTH 4

// Credits the sink grants after reset
`define OUTPUT_CREDITS 4
`define CREDIT_COUNT_WIDTH 4

`endif

// File: stream_mux_pkg.sv
// ********************
// Stream selector types
// Field vectors, channel address, credit count and scheduler states
// ********************

`include "stream_mux_cfg.svh"

package stream_mux_pkg;

    // Fields of one stream word
    typedef logic [`DATA_WIDTH-1:0] sample_t;
    typedef logic [`DEST_WIDTH-1:0] dest_t;
    typedef logic [`USER_WIDTH-1:0] user_t;

    // Address of a source channel, values at or above CHANNEL_COUNT select nothing
    typedef logic [`CHANNEL_INDEX_WIDTH-1:0] channel_index_t;

    // Outstanding downstream credits
    typedef logic [`CREDIT_COUNT_WIDTH-1:0] credit_count_t;

    // Packet scheduler states
    typedef enum logic [0:0] {
        sched_idle,
        sched_forward
    } sched_state_t;

endpackage

// File: channel_buffer.sv
// ********************
// Channel buffer
// Small circular FIFO for one source channel, returns a credit
// to the source one cycle after each word is drained
// ********************

`include "stream_mux_cfg.svh"

module channel_buffer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic                     in_last,
    input  stream_mux_pkg::sample_t  in_data,
    input  stream_mux_pkg::dest_t    in_dest,
    input  stream_mux_pkg::user_t    in_user,
    input  logic                     pop,
    output stream_mux_pkg::sample_t  head_data,
    output stream_mux_pkg::dest_t    head_dest,
    output stream_mux_pkg::user_t    head_user,
    output logic                     head_last,
    output logic                     not_empty,
    output logic                     credit_return
);
    import stream_mux_pkg::*;

    localparam int PTR_WIDTH = (`BUFFER_DEPTH > 1) ? $clog2(`BUFFER_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(`BUFFER_DEPTH + 1);

    sample_t mem_data [`BUFFER_DEPTH];
    dest_t   mem_dest [`BUFFER_DEPTH];
    user_t   mem_user [`BUFFER_DEPTH];
    logic    mem_last [`BUFFER_DEPTH];

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_pop;

    // The scheduler only pops a non-empty buffer, this keeps the pointers safe anyway
    assign do_pop = pop & not_empty;
    assign not_empty = (count != '0);

    assign head_data = mem_data[rd_ptr];
    assign head_dest = mem_dest[rd_ptr];
    assign head_user = mem_user[rd_ptr];
    assign head_last = mem_last[rd_ptr];

    // Storage, the source never writes without a free slot
    always_ff @(posedge clock) begin
        if (in_valid) begin
            mem_data[wr_ptr] <= in_data;
            mem_dest[wr_ptr] <= in_dest;
            mem_user[wr_ptr] <= in_user;
            mem_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid) begin
                if (wr_ptr == PTR_WIDTH'(`BUFFER_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == PTR_WIDTH'(`BUFFER_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Occupancy is unchanged when a write and a pop meet
            case ({in_valid, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to the source for every drained word
            credit_return <= do_pop;
        end
    end

endmodule

// File: output_credit_counter.sv
// ********************
// Output credit counter
// Tracks the words the sink has granted but not yet received
// ********************

`include "stream_mux_cfg.svh"

module output_credit_counter (
    input  logic clock,
    input  logic reset,
    input  logic pop,
    input  logic out_credit,
    output logic credit_available
);
    import stream_mux_pkg::*;

    credit_count_t count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= credit_count_t'(`OUTPUT_CREDITS);
        end else begin
            // A pop spends a credit and a pulse grants one, both together cancel out
            case ({pop, out_credit})
                2'b10: count <= count - 1'b1;
                2'b01: count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign credit_available = (count != '0);

endmodule

// File: packet_scheduler_fsm.sv
// ********************
// Packet scheduler
// Samples the address between packets and pops the chosen
// buffer word by word until the last word has gone out
// ********************

`include "stream_mux_cfg.svh"

module packet_scheduler_fsm (
    input  logic                           clock,
    input  logic                           reset,
    input  stream_mux_pkg::channel_index_t address,
    input  logic                           not_empty [`CHANNEL_COUNT],
    input  logic                           head_last [`CHANNEL_COUNT],
    input  logic                           credit_available,
    output stream_mux_pkg::channel_index_t select,
    output logic                           pop
);
    import stream_mux_pkg::*;

    sched_state_t state;
    logic         address_ready;
    logic         selected_not_empty;
    logic         selected_last;

    // Addresses outside the channel range never match, so they start nothing
    always_comb begin
        address_ready = 1'b0;
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            if (address == channel_index_t'(c)) begin
                address_ready = not_empty[c];
            end
        end
    end

    // The latched select always names an existing channel
    always_comb begin
        selected_not_empty = 1'b0;
        selected_last      = 1'b0;
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            if (select == channel_index_t'(c)) begin
                selected_not_empty = not_empty[c];
                selected_last      = head_last[c];
            end
        end
    end

    // At most one word per cycle, and only with a sink credit in hand
    assign pop = (state == sched_forward) && selected_not_empty && credit_available;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state  <= sched_idle;
            select <= '0;
        end else begin
            case (state)
                sched_idle: begin
                    if (address_ready) begin
                        select <= address;
                        state  <= sched_forward;
                    end
                end
                sched_forward: begin
                    // The packet ends with the word that carries last
                    if (pop && selected_last) begin
                        state <= sched_idle;
                    end
                end
                default: state <= sched_idle;
            endcase
        end
    end

endmodule

// File: stream_select_mux.sv
// ********************
// Output select stage
// Registers the popped head word of the selected channel
// onto the output stream
// ********************

`include "stream_mux_cfg.svh"

module stream_select_mux (
    input  logic                           clock,
    input  logic                           reset,
    input  stream_mux_pkg::channel_index_t select,
    input  logic                           pop,
    input  stream_mux_pkg::sample_t        head_data [`CHANNEL_COUNT],
    input  stream_mux_pkg::dest_t          head_dest [`CHANNEL_COUNT],
    input  stream_mux_pkg::user_t          head_user [`CHANNEL_COUNT],
    input  logic                           head_last [`CHANNEL_COUNT],
    output logic                           out_valid,
    output stream_mux_pkg::sample_t        out_data,
    output stream_mux_pkg::dest_t          out_dest,
    output stream_mux_pkg::user_t          out_user,
    output logic                           out_last
);

    // Valid marks exactly the cycles that carry a popped word
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    // Payload only changes when a word is popped, select is always in range here
    always_ff @(posedge clock) begin
        if (pop) begin
            out_data <= head_data[select];
            out_dest <= head_dest[select];
            out_user <= head_user[select];
            out_last <= head_last[select];
        end
    end

endmodule

// File: stream_mux_top.sv
// ********************
// Packet-aware stream selector
// Five credit-controlled source channels forwarded one packet
// at a time onto a single credit-controlled output stream
// ********************

`include "stream_mux_cfg.svh"

module stream_mux_top (
    input  logic                           clock,
    input  logic                           reset,
    input  stream_mux_pkg::channel_index_t address,
    input  logic                           out_credit,
    input  logic                           in_valid [`CHANNEL_COUNT],
    input  stream_mux_pkg::sample_t        in_data [`CHANNEL_COUNT],
    input  stream_mux_pkg::dest_t          in_dest [`CHANNEL_COUNT],
    input  stream_mux_pkg::user_t          in_user [`CHANNEL_COUNT],
    input  logic                           in_last [`CHANNEL_COUNT],
    output logic                           credit_return [`CHANNEL_COUNT],
    output logic                           out_valid,
    output stream_mux_pkg::sample_t        out_data,
    output stream_mux_pkg::dest_t          out_dest,
    output stream_mux_pkg::user_t          out_user,
    output logic                           out_last
);
    import stream_mux_pkg::*;

    sample_t        head_data [`CHANNEL_COUNT];
    dest_t          head_dest [`CHANNEL_COUNT];
    user_t          head_user [`CHANNEL_COUNT];
    logic           head_last [`CHANNEL_COUNT];
    logic           not_empty [`CHANNEL_COUNT];
    logic           buffer_pop [`CHANNEL_COUNT];
    channel_index_t select;
    logic           pop;
    logic           credit_available;

    for (genvar c = 0; c < `CHANNEL_COUNT; c++) begin : g_channel
        // Only the buffer named by the latched select sees the pop
        assign buffer_pop[c] = pop && (select == channel_index_t'(c));

        channel_buffer channel_buffer_i (
            .clock         (clock),
            .reset         (reset),
            .in_valid      (in_valid[c]),
            .in_last       (in_last[c]),
            .in_data       (in_data[c]),
            .in_dest       (in_dest[c]),
            .in_user       (in_user[c]),
            .pop           (buffer_pop[c]),
            .head_data     (head_data[c]),
            .head_dest     (head_dest[c]),
            .head_user     (head_user[c]),
            .head_last     (head_last[c]),
            .not_empty     (not_empty[c]),
            .credit_return (credit_return[c])
        );
    end

    packet_scheduler_fsm packet_scheduler_fsm_i (
        .clock            (clock),
        .reset            (reset),
        .address          (address),
        .not_empty        (not_empty),
        .head_last        (head_last),
        .credit_available (credit_available),
        .select           (select),
        .pop              (pop)
    );

    output_credit_counter output_credit_counter_i (
        .clock            (clock),
        .reset            (reset),
        .pop              (pop),
        .out_credit       (out_credit),
        .credit_available (credit_available)
    );

    stream_select_mux stream_select_mux_i (
        .clock     (clock),
        .reset     (reset),
        .select    (select),
        .pop       (pop),
        .head_data (head_data),
        .head_dest (head_dest),
        .head_user (head_user),
        .head_last (head_last),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_user  (out_user),
        .out_last  (out_last)
    );

endmodule

// File: stream_mux_tb.sv
// ********************
// Stream selector testbench
// Directed and random packet tests with source and sink credit models
// ********************

`include "stream_mux_cfg.svh"

module stream_mux_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import stream_mux_pkg::*;

    localparam int WORD_WIDTH = `DATA_WIDTH + `DEST_WIDTH + `USER_WIDTH + 1;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int STALL_WORDS = 10;

    // A whole stream word as data, dest, user and last
    typedef logic [WORD_WIDTH-1:0] word_t;

    logic           clock;
    logic           reset;
    channel_index_t address;
    logic           out_credit;
    logic           in_valid [`CHANNEL_COUNT];
    sample_t        in_data [`CHANNEL_COUNT];
    dest_t          in_dest [`CHANNEL_COUNT];
    user_t          in_user [`CHANNEL_COUNT];
    logic           in_last [`CHANNEL_COUNT];
    logic           credit_return [`CHANNEL_COUNT];
    logic           out_valid;
    sample_t        out_data;
    dest_t          out_dest;
    user_t          out_user;
    logic           out_last;

    // Words waiting at each source, words expected at the sink and words received
    word_t src_q [`CHANNEL_COUNT][$];
    word_t exp_q [$];
    word_t rx_q [$];
    int    src_credits [`CHANNEL_COUNT];
    int    returns_seen [`CHANNEL_COUNT];
    int    sink_credits;
    int    grant_pending;
    bit    auto_grant;
    string test_name;

    stream_mux_top stream_mux_top_i (
        .clock         (clock),
        .reset         (reset),
        .address       (address),
        .out_credit    (out_credit),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_dest       (in_dest),
        .in_user       (in_user),
        .in_last       (in_last),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_dest      (out_dest),
        .out_user      (out_user),
        .out_last      (out_last)
    );

    always #20 clock = ~clock;

    task automatic check(string what, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error in %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Each step samples the DUT at the falling edge, updates the models and drives the inputs
    task automatic step();
        word_t w;
        @(negedge clock);
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            if (credit_return[c]) begin
                src_credits[c]++;
                returns_seen[c]++;
                check("source credit bound", 64'(1), 64'(src_credits[c] <= `BUFFER_DEPTH));
            end
        end
        if (out_valid) begin
            rx_q.push_back({out_data, out_dest, out_user, out_last});
            sink_credits--;
            check("sink credit bound", 64'(1), 64'(sink_credits >= 0));
            if (auto_grant) begin
                grant_pending++;
            end
        end
        out_credit = 1'b0;
        if (grant_pending > 0) begin
            out_credit = 1'b1;
            grant_pending--;
            sink_credits++;
        end
        // A source only sends while it holds a credit
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            in_valid[c] = 1'b0;
            if (src_q[c].size() > 0 && src_credits[c] > 0) begin
                w = src_q[c].pop_front();
                {in_data[c], in_dest[c], in_user[c], in_last[c]} = w;
                in_valid[c] = 1'b1;
                src_credits[c]--;
            end
        end
    endtask

    task automatic settle(int cycles);
        repeat (cycles) step();
    endtask

    task automatic wait_words(int count);
        int cycles;
        cycles = 0;
        while (rx_q.size() < count) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Timeout in %s: %0d of %0d words arrived", test_name, rx_q.size(), count);
                $display("Simulation FAILED");
                $fatal(1);
            end else begin
                step();
                cycles++;
            end
        end
    endtask

    task automatic queue_packet(int c, int len);
        word_t w;
        for (int i = 0; i < len; i++) begin
            w = {sample_t'($urandom), dest_t'($urandom), user_t'($urandom), i == len - 1};
            src_q[c].push_back(w);
            exp_q.push_back(w);
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            returns_seen[c] = 0;
        end
    endtask

    // Lets the last sink credit go back, then compares every received word in order
    task automatic end_test();
        settle(4);
        check("word count", 64'(exp_q.size()), 64'(rx_q.size()));
        for (int i = 0; i < exp_q.size(); i++) begin
            check($sformatf("word %0d", i), 64'(exp_q[i]), 64'(rx_q[i]));
        end
        exp_q.delete();
        rx_q.delete();
    endtask

    task automatic test_reset_idle();
        start_test("reset_idle");
        for (int n = 0; n < 8; n++) begin
            step();
            check("out_valid", 64'(0), 64'(out_valid));
            for (int c = 0; c < `CHANNEL_COUNT; c++) begin
                check($sformatf("credit_return %0d", c), 64'(0), 64'(credit_return[c]));
            end
        end
    endtask

    task automatic test_single_packet();
        start_test("single_packet");
        address = channel_index_t'(2);
        queue_packet(2, 3);
        wait_words(3);
        end_test();
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            check($sformatf("credit returns %0d", c), 64'(c == 2 ? 3 : 0), 64'(returns_seen[c]));
        end
    endtask

    // The address moves on mid-packet while the channel 1 packet still completes first
    task automatic test_address_change();
        start_test("address_change");
        address = channel_index_t'(1);
        queue_packet(1, 6);
        queue_packet(3, 3);
        wait_words(2);
        address = channel_index_t'(3);
        wait_words(9);
        end_test();
    endtask

    task automatic test_backpressure();
        start_test("backpressure");
        auto_grant = 1'b0;
        address = channel_index_t'(4);
        queue_packet(4, STALL_WORDS);
        settle(30);
        check("words while stalled", 64'(`OUTPUT_CREDITS), 64'(rx_q.size()));
        check("source credits while stalled", 64'(0), 64'(src_credits[4]));
        check("words held at source", 64'(STALL_WORDS - `OUTPUT_CREDITS - `BUFFER_DEPTH),
              64'(src_q[4].size()));
        // The sink now grants back the words it already took
        auto_grant = 1'b1;
        grant_pending = `OUTPUT_CREDITS;
        wait_words(STALL_WORDS);
        end_test();
    endtask

    task automatic test_bad_address();
        start_test("bad_address");
        address = channel_index_t'(5);
        queue_packet(0, 3);
        for (int a = 5; a < 8; a++) begin
            address = channel_index_t'(a);
            settle(8);
            check($sformatf("words at address %0d", a), 64'(0), 64'(rx_q.size()));
        end
        address = channel_index_t'(0);
        wait_words(3);
        end_test();
    endtask

    task automatic test_random_packets();
        int target;
        int len [`CHANNEL_COUNT];
        start_test("random_packets");
        target = 0;
        for (int round = 0; round < 3; round++) begin
            // Park the address on an unused value so no channel starts early
            address = channel_index_t'(7);
            for (int c = 0; c < `CHANNEL_COUNT; c++) begin
                len[c] = int'($urandom_range(6, 1));
                queue_packet(c, len[c]);
            end
            settle(8);
            check("words while parked", 64'(target), 64'(rx_q.size()));
            for (int c = 0; c < `CHANNEL_COUNT; c++) begin
                target += len[c];
                address = channel_index_t'(c);
                wait_words(target);
            end
        end
        end_test();
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            check($sformatf("final credits %0d", c), 64'(`BUFFER_DEPTH), 64'(src_credits[c]));
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        address = '0;
        out_credit = 1'b0;
        for (int c = 0; c < `CHANNEL_COUNT; c++) begin
            in_valid[c] = 1'b0;
            in_data[c] = '0;
            in_dest[c] = '0;
            in_user[c] = '0;
            in_last[c] = 1'b0;
            src_credits[c] = `BUFFER_DEPTH;
            returns_seen[c] = 0;
        end
        sink_credits = `OUTPUT_CREDITS;
        grant_pending = 0;
        auto_grant = 1'b1;
        test_name = "reset";
        void'($urandom(68443));
        repeat (2) @(negedge clock);
        reset = 1'b1;
        test_reset_idle();
        test_single_packet();
        test_address_change();
        test_backpressure();
        test_bad_address();
        test_random_packets();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
stream_mux_pkg.sv
channel_buffer.sv
output_credit_counter.sv
packet_scheduler_fsm.sv
stream_select_mux.sv
stream_mux_top.sv
stream_mux_tb.sv

// File: Makefile
# Verilator build and run for the stream selector

VERILATOR       ?= verilator
TOP             ?= stream_mux_tb
FILE_LIST       ?= vlog.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing
PASS_TEXT       ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
